//--- vdp_pkg.sv
package vdp_pkg;

  // -------------------------------------------------------------------
  // Raster geometry
  // -------------------------------------------------------------------

  // Width of the cx and cy output raster coordinates
  localparam int raster_w = 10;

  // Display line number and line-match register
  localparam int line_w = 8;

  // -------------------------------------------------------------------
  // Colour widths
  // -------------------------------------------------------------------

  // Internal channel as delivered by the pixel pipeline
  localparam int chan_w = 6;

  // Output channel towards the video DAC
  localparam int out_w = 8;

  // Border colour packed as green, red and blue from high to low
  localparam int border_w = 9;

  // -------------------------------------------------------------------
  // Field end lines counted in output (doubled) lines
  // -------------------------------------------------------------------

  // Progressive frames
  localparam logic [raster_w-1:0] ntsc_end_prog = 10'd524;
  localparam logic [raster_w-1:0] pal_end_prog = 10'd626;

  // Interlaced fields
  localparam logic [raster_w-1:0] ntsc_end_il = 10'd525;
  localparam logic [raster_w-1:0] pal_end_il = 10'd625;

endpackage

//--- vdp_frame_zone.sv
`timescale 1ns/1ps

module vdp_frame_zone #(
  parameter int top_border_lines = 20
) (
  input  logic                         reset,
  input  logic                         clk21m,
  input  logic [vdp_pkg::raster_w-1:0] cx,
  input  logic [vdp_pkg::raster_w-1:0] cy,
  input  logic                         pal_mode,
  input  logic                         interlace_mode,
  output logic                         bwindow_y,
  output logic [vdp_pkg::line_w-1:0]   line_y,
  output logic                         line_start,
  output logic                         v_blank_start
);

  // Top border in output lines with two per display line
  localparam int open_line_i = 2 * top_border_lines;
  localparam logic [vdp_pkg::raster_w-1:0] open_line = open_line_i[vdp_pkg::raster_w-1:0];

  logic [vdp_pkg::raster_w-1:0] field_end;
  logic [vdp_pkg::raster_w-1:0] reopen_line;
  logic [vdp_pkg::raster_w-1:0] line_ofs;
  logic                         bwindow_prev;

  // Field end per video standard
  always_comb begin
    case ({pal_mode, interlace_mode})
      2'b00:   field_end = vdp_pkg::ntsc_end_prog;
      2'b01:   field_end = vdp_pkg::ntsc_end_il;
      2'b10:   field_end = vdp_pkg::pal_end_prog;
      default: field_end = vdp_pkg::pal_end_il;
    endcase
  end

  // Odd field starts half a line late, so interlace opens one line later
  assign reopen_line = field_end + open_line
                     + {{(vdp_pkg::raster_w-1){1'b0}}, interlace_mode};

  assign line_ofs = cy - open_line;

  // -------------------------------------------------------------------
  // Vertical border window
  // -------------------------------------------------------------------
  always_ff @(posedge reset, posedge clk21m) begin
    if (clk21m) begin
      bwindow_y <= 1'b0;
    end else begin
      if (cy == open_line || cy == reopen_line) begin
        bwindow_y <= 1'b1;
      end else if (cy == '0 || cy == field_end) begin
        bwindow_y <= 1'b0;
      end
    end
  end

  // Line number, line start and blanking pulse
  always_ff @(posedge reset, posedge clk21m) begin
    if (clk21m) begin
      line_y        <= '0;
      line_start    <= 1'b0;
      bwindow_prev  <= 1'b0;
      v_blank_start <= 1'b0;
    end else begin
      line_y        <= line_ofs[vdp_pkg::line_w:1];
      line_start    <= (cx == '0) && !cy[0];
      bwindow_prev  <= bwindow_y;
      // Falling edge of the window seen one cycle late
      v_blank_start <= bwindow_prev && !bwindow_y;
    end
  end

  a_vblank_single : assert property (
    @(posedge reset) disable iff (clk21m)
    v_blank_start |=> !v_blank_start
  );

endmodule

//--- vdp_interrupt.sv
`timescale 1ns/1ps

module vdp_interrupt (
  input  logic                       reset,
  input  logic                       clk21m,
  input  logic                       bwindow_y,
  input  logic [vdp_pkg::line_w-1:0] line_y,
  input  logic                       line_start,
  input  logic                       v_blank_start,
  input  logic                       vsync_int_en,
  input  logic                       hsync_int_en,
  input  logic [vdp_pkg::line_w-1:0] hsync_int_line,
  input  logic                       clr_vsync_int,
  input  logic                       clr_hsync_int,
  output logic                       int_n
);

  logic vsync_req;
  logic hsync_req;
  logic hsync_hit;
  logic pending;

  // Line match only counts inside the frame zone
  assign hsync_hit = line_start && bwindow_y && (line_y == hsync_int_line);

  assign pending = (vsync_req && vsync_int_en) || (hsync_req && hsync_int_en);

  // -------------------------------------------------------------------
  // Request flags where set wins over clear
  // -------------------------------------------------------------------
  always_ff @(posedge reset, posedge clk21m) begin
    if (clk21m) begin
      vsync_req <= 1'b0;
      hsync_req <= 1'b0;
    end else begin
      if (v_blank_start) begin
        vsync_req <= 1'b1;
      end else if (clr_vsync_int) begin
        vsync_req <= 1'b0;
      end

      if (hsync_hit) begin
        hsync_req <= 1'b1;
      end else if (clr_hsync_int) begin
        hsync_req <= 1'b0;
      end
    end
  end

  // Combined active-low output
  always_ff @(posedge reset, posedge clk21m) begin
    if (clk21m) begin
      int_n <= 1'b1;
    end else begin
      int_n <= !pending;
    end
  end

  a_int_has_source : assert property (
    @(posedge reset) disable iff (clk21m)
    !int_n |-> $past(pending)
  );

endmodule

//--- vdp_video_out.sv
`timescale 1ns/1ps

module vdp_video_out (
  input  logic                         reset,
  input  logic                         clk21m,
  input  logic                         bwindow_y,
  input  logic [vdp_pkg::raster_w-1:0] cy,
  input  logic                         scanlin,
  input  logic [vdp_pkg::border_w-1:0] border_col,
  input  logic [vdp_pkg::chan_w-1:0]   pix_r,
  input  logic [vdp_pkg::chan_w-1:0]   pix_g,
  input  logic [vdp_pkg::chan_w-1:0]   pix_b,
  output logic [vdp_pkg::out_w-1:0]    red,
  output logic [vdp_pkg::out_w-1:0]    green,
  output logic [vdp_pkg::out_w-1:0]    blue
);

  logic [vdp_pkg::chan_w-1:0] pix_r_q;
  logic [vdp_pkg::chan_w-1:0] pix_g_q;
  logic [vdp_pkg::chan_w-1:0] pix_b_q;
  logic                       odd_q;
  logic                       scan_q;
  logic [vdp_pkg::chan_w-1:0] sel_r;
  logic [vdp_pkg::chan_w-1:0] sel_g;
  logic [vdp_pkg::chan_w-1:0] sel_b;
  logic                       dark;

  // 6 to 8 bit expansion with halved brightness on darkened lines
  function automatic logic [vdp_pkg::out_w-1:0] expand(
    input logic [vdp_pkg::chan_w-1:0] val,
    input logic                       dim
  );
    if (dim) begin
      return {1'b0, val, 1'b0};
    end
    return {val, 2'b00};
  endfunction

  // -------------------------------------------------------------------
  // Stage one lines up with the frame zone
  // -------------------------------------------------------------------
  always_ff @(posedge reset) begin
    pix_r_q <= pix_r;
    pix_g_q <= pix_g;
    pix_b_q <= pix_b;
  end

  always_ff @(posedge reset, posedge clk21m) begin
    if (clk21m) begin
      odd_q  <= 1'b0;
      scan_q <= 1'b0;
    end else begin
      odd_q  <= cy[0];
      scan_q <= scanlin;
    end
  end

  // Border fields doubled from 3 to 6 bits
  always_comb begin
    if (bwindow_y) begin
      sel_r = pix_r_q;
      sel_g = pix_g_q;
      sel_b = pix_b_q;
    end else begin
      sel_g = {border_col[8:6], border_col[8:6]};
      sel_r = {border_col[5:3], border_col[5:3]};
      sel_b = {border_col[2:0], border_col[2:0]};
    end
  end

  assign dark = scan_q && odd_q;

  // Stage two output registers
  always_ff @(posedge reset, posedge clk21m) begin
    if (clk21m) begin
      red   <= '0;
      green <= '0;
      blue  <= '0;
    end else begin
      red   <= expand(sel_r, dark);
      green <= expand(sel_g, dark);
      blue  <= expand(sel_b, dark);
    end
  end

endmodule

//--- vdp_display.sv
`timescale 1ns/1ps

module vdp_display #(
  parameter int top_border_lines = 20
) (
  input  logic                         reset,
  input  logic                         clk21m,
  input  logic [vdp_pkg::raster_w-1:0] cx,
  input  logic [vdp_pkg::raster_w-1:0] cy,
  input  logic                         pal_mode,
  input  logic                         interlace_mode,
  input  logic                         scanlin,
  input  logic                         vsync_int_en,
  input  logic                         hsync_int_en,
  input  logic [vdp_pkg::line_w-1:0]   hsync_int_line,
  input  logic [vdp_pkg::border_w-1:0] border_col,
  input  logic [vdp_pkg::chan_w-1:0]   pix_r,
  input  logic [vdp_pkg::chan_w-1:0]   pix_g,
  input  logic [vdp_pkg::chan_w-1:0]   pix_b,
  input  logic                         clr_vsync_int,
  input  logic                         clr_hsync_int,
  output logic                         int_n,
  output logic [vdp_pkg::out_w-1:0]    red,
  output logic [vdp_pkg::out_w-1:0]    green,
  output logic [vdp_pkg::out_w-1:0]    blue
);

  logic                       bwindow_y;
  logic [vdp_pkg::line_w-1:0] line_y;
  logic                       line_start;
  logic                       v_blank_start;

  // -------------------------------------------------------------------
  // Frame zone, then interrupts and video output
  // -------------------------------------------------------------------
  vdp_frame_zone #(
    .top_border_lines(top_border_lines)
  ) i_frame_zone (
    .reset         (reset),
    .clk21m        (clk21m),
    .cx            (cx),
    .cy            (cy),
    .pal_mode      (pal_mode),
    .interlace_mode(interlace_mode),
    .bwindow_y     (bwindow_y),
    .line_y        (line_y),
    .line_start    (line_start),
    .v_blank_start (v_blank_start)
  );

  vdp_interrupt i_interrupt (
    .reset         (reset),
    .clk21m        (clk21m),
    .bwindow_y     (bwindow_y),
    .line_y        (line_y),
    .line_start    (line_start),
    .v_blank_start (v_blank_start),
    .vsync_int_en  (vsync_int_en),
    .hsync_int_en  (hsync_int_en),
    .hsync_int_line(hsync_int_line),
    .clr_vsync_int (clr_vsync_int),
    .clr_hsync_int (clr_hsync_int),
    .int_n         (int_n)
  );

  vdp_video_out i_video_out (
    .reset     (reset),
    .clk21m    (clk21m),
    .bwindow_y (bwindow_y),
    .cy        (cy),
    .scanlin   (scanlin),
    .border_col(border_col),
    .pix_r     (pix_r),
    .pix_g     (pix_g),
    .pix_b     (pix_b),
    .red       (red),
    .green     (green),
    .blue      (blue)
  );

endmodule

//--- tb_vdp_display.sv
`timescale 1ns/1ps

module tb_vdp_display;

  localparam int top_border_lines = 20;
  localparam int open_line = 2 * top_border_lines;

  typedef struct packed {
    logic [9:0] cx;
    logic [9:0] cy;
    logic       pal;
    logic       il;
    logic       scan;
    logic       ven;
    logic       hen;
    logic [7:0] hline;
    logic [8:0] border;
    logic       clrv;
    logic       clrh;
    logic [7:0] rep;
  } stim_row_t;

  // Clock arrives on reset and the asynchronous reset on clk21m
  logic       reset;
  logic       clk21m;
  logic [9:0] cx;
  logic [9:0] cy;
  logic       pal_mode;
  logic       interlace_mode;
  logic       scanlin;
  logic       vsync_int_en;
  logic       hsync_int_en;
  logic [7:0] hsync_int_line;
  logic [8:0] border_col;
  logic [5:0] pix_r;
  logic [5:0] pix_g;
  logic [5:0] pix_b;
  logic       clr_vsync_int;
  logic       clr_hsync_int;
  logic       int_n;
  logic [7:0] red;
  logic [7:0] green;
  logic [7:0] blue;

  // Reference model state
  logic        m_bwin;
  logic        m_bwin_prev;
  logic [7:0]  m_line_y;
  logic        m_line_start;
  logic        m_vblank;
  logic        m_vreq;
  logic        m_hreq;
  logic        m_int_n;
  logic [17:0] m_pix_q;
  logic        m_odd;
  logic        m_scan;
  logic [7:0]  m_red;
  logic [7:0]  m_green;
  logic [7:0]  m_blue;

  stim_row_t stim_tbl[$];
  int        checks;
  int        err_count[3];

  vdp_display i_vdp_display (
    .reset(reset), .clk21m(clk21m), .cx(cx), .cy(cy),
    .pal_mode(pal_mode), .interlace_mode(interlace_mode), .scanlin(scanlin),
    .vsync_int_en(vsync_int_en), .hsync_int_en(hsync_int_en),
    .hsync_int_line(hsync_int_line), .border_col(border_col),
    .pix_r(pix_r), .pix_g(pix_g), .pix_b(pix_b),
    .clr_vsync_int(clr_vsync_int), .clr_hsync_int(clr_hsync_int),
    .int_n(int_n), .red(red), .green(green), .blue(blue)
  );

  always #10 reset = ~reset;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic logic [9:0] field_end(input logic pal, input logic il);
    if (pal) begin
      return il ? vdp_pkg::pal_end_il : vdp_pkg::pal_end_prog;
    end
    return il ? vdp_pkg::ntsc_end_il : vdp_pkg::ntsc_end_prog;
  endfunction

  // 3-bit border field repeated twice
  function automatic logic [5:0] double_field(input logic [2:0] f);
    return {3'b000, f} * 6'd9;
  endfunction

  // Darkened lines carry half the brightness
  function automatic logic [7:0] widen(input logic [5:0] v, input logic dim);
    return dim ? ({2'b00, v} << 1) : ({2'b00, v} << 2);
  endfunction

  // -------------------------------------------------------------------
  // Stimulus table
  // -------------------------------------------------------------------
  // modes packs {pal, il, scan, ven, hen} and clrs packs {clrv, clrh}
  task automatic add_row(input logic [9:0] x, input logic [9:0] y, input logic [4:0] modes,
                         input logic [7:0] hline, input logic [8:0] border,
                         input logic [1:0] clrs, input logic [7:0] rep);
    stim_tbl.push_back({x, y, modes, hline, border, clrs, rep});
  endtask

  // Closed, open, field end, reopen, closed again
  task automatic walk_mode(input logic pal, input logic il, input logic scan,
                           input logic ven, input logic [8:0] border);
    logic [9:0] fend;
    logic [4:0] m;
    fend = field_end(pal, il);
    m = {pal, il, scan, ven, 1'b0};
    add_row(10'd5, 10'd0, m, 8'd0, border, 2'b00, 8'd3);
    add_row(10'd5, 10'd40, m, 8'd0, border, 2'b00, 8'd3);
    add_row(10'd5, 10'd41, m, 8'd0, border, 2'b00, 8'd3);
    add_row(10'd5, 10'd42, m, 8'd0, border, 2'b00, 8'd2);
    add_row(10'd5, fend, m, 8'd0, border, 2'b00, 8'd4);
    add_row(10'd5, fend + 10'd1, m, 8'd0, border, 2'b00, 8'd2);
    add_row(10'd5, fend + open_line + il, m, 8'd0, border, 2'b00, 8'd3);
    add_row(10'd5, fend + open_line + il + 1, m, 8'd0, border, 2'b00, 8'd3);
    add_row(10'd5, 10'd0, m, 8'd0, border, 2'b00, 8'd4);
  endtask

  task automatic build_table();
    walk_mode(1'b0, 1'b0, 1'b1, 1'b0, 9'h1a5);
    add_row(10'd5, 10'd0, 5'b00000, 8'd0, 9'h1a5, 2'b10, 8'd1);
    walk_mode(1'b1, 1'b0, 1'b0, 1'b1, 9'h0c7);
    add_row(10'd5, 10'd0, 5'b10010, 8'd0, 9'h0c7, 2'b10, 8'd1);
    add_row(10'd5, 10'd0, 5'b10010, 8'd0, 9'h0c7, 2'b00, 8'd3);
    walk_mode(1'b0, 1'b1, 1'b1, 1'b0, 9'h13a);
    walk_mode(1'b1, 1'b1, 1'b1, 1'b0, 9'h1ff);
    add_row(10'd5, 10'd0, 5'b00100, 8'd0, 9'h052, 2'b10, 8'd1);
    // Line match inside the window and then outside it
    add_row(10'd5, 10'd40, 5'b00001, 8'd10, 9'h052, 2'b00, 8'd2);
    add_row(10'd0, 10'd62, 5'b00001, 8'd10, 9'h052, 2'b00, 8'd3);
    add_row(10'd0, 10'd60, 5'b00001, 8'd10, 9'h052, 2'b00, 8'd1);
    add_row(10'd5, 10'd60, 5'b00001, 8'd10, 9'h052, 2'b00, 8'd4);
    add_row(10'd5, 10'd60, 5'b00001, 8'd10, 9'h052, 2'b01, 8'd1);
    add_row(10'd5, 10'd60, 5'b00001, 8'd10, 9'h052, 2'b00, 8'd3);
    add_row(10'd5, 10'd0, 5'b00001, 8'd246, 9'h052, 2'b00, 8'd3);
    add_row(10'd0, 10'd20, 5'b00001, 8'd246, 9'h052, 2'b00, 8'd4);
  endtask

  // -------------------------------------------------------------------
  // Reference model stepped once per rising edge
  // -------------------------------------------------------------------
  task automatic step_model();
    logic [9:0] ofs;
    logic       dim;
    m_int_n = !((m_vreq && vsync_int_en) || (m_hreq && hsync_int_en));
    m_vreq = m_vblank ? 1'b1 : (clr_vsync_int ? 1'b0 : m_vreq);
    if (m_line_start && m_bwin && m_line_y == hsync_int_line) begin
      m_hreq = 1'b1;
    end else if (clr_hsync_int) begin
      m_hreq = 1'b0;
    end
    dim = m_scan && m_odd;
    m_red = widen(m_bwin ? m_pix_q[17:12] : double_field(border_col[5:3]), dim);
    m_green = widen(m_bwin ? m_pix_q[11:6] : double_field(border_col[8:6]), dim);
    m_blue = widen(m_bwin ? m_pix_q[5:0] : double_field(border_col[2:0]), dim);
    m_pix_q = {pix_r, pix_g, pix_b};
    m_odd = cy[0];
    m_scan = scanlin;
    m_vblank = m_bwin_prev && !m_bwin;
    m_bwin_prev = m_bwin;
    if (cy == open_line || cy == field_end(pal_mode, interlace_mode) + open_line
        + interlace_mode) begin
      m_bwin = 1'b1;
    end else if (cy == 0 || cy == field_end(pal_mode, interlace_mode)) begin
      m_bwin = 1'b0;
    end
    ofs = cy - open_line;
    m_line_y = ofs[8:1];
    m_line_start = (cx == 0) && !cy[0];
  endtask

  task automatic check_value(input string name, input int kind, input logic [7:0] expected,
                             input logic [7:0] actual);
    checks++;
    assert (actual === expected) else begin
      err_count[kind]++;
      $display("[ERROR] %0t %s expected %0h actual %0h", $time, name, expected, actual);
    end
  endtask

  task automatic compare_outputs();
    check_value("bwindow_y", 0, m_bwin, i_vdp_display.bwindow_y);
    check_value("int_n", 1, m_int_n, int_n);
    check_value("red", 2, m_red, red);
    check_value("green", 2, m_green, green);
    check_value("blue", 2, m_blue, blue);
  endtask

  initial begin
    int        total;
    int        limit_ns;
    logic [31:0] seed;
    stim_row_t row;
    reset = 1'b0;
    clk21m = 1'b1;
    {cx, cy, pal_mode, interlace_mode, scanlin} = '0;
    {vsync_int_en, hsync_int_en, hsync_int_line, border_col} = '0;
    {pix_r, pix_g, pix_b, clr_vsync_int, clr_hsync_int} = '0;
    {m_bwin, m_bwin_prev, m_line_y, m_line_start, m_vblank, m_vreq, m_hreq} = '0;
    {m_pix_q, m_odd, m_scan, m_red, m_green, m_blue} = '0;
    m_int_n = 1'b1;
    checks = 0;
    err_count = '{0, 0, 0};
    build_table();
    total = 0;
    foreach (stim_tbl[i]) begin
      total += stim_tbl[i].rep;
    end
    limit_ns = (8 + total + 50) * 20;
    fork
      begin
        #(limit_ns);
        $display("Timeout after %0d ns, the stimulus table never finished", limit_ns);
        $display("TESTBENCH FAILED");
        $finish;
      end
    join_none
    repeat (8) @(posedge reset);
    #1;
    clk21m = 1'b0;
    compare_outputs();
    seed = 32'h7111;
    foreach (stim_tbl[i]) begin
      row = stim_tbl[i];
      for (int r = 0; r < row.rep; r++) begin
        seed = xorshift32(seed);
        {cx, cy, pal_mode, interlace_mode, scanlin} = {row.cx, row.cy, row.pal, row.il, row.scan};
        {vsync_int_en, hsync_int_en, hsync_int_line} = {row.ven, row.hen, row.hline};
        {border_col, clr_vsync_int, clr_hsync_int} = {row.border, row.clrv, row.clrh};
        {pix_r, pix_g, pix_b} = {seed[5:0], seed[13:8], seed[21:16]};
        @(posedge reset);
        #1;
        step_model();
        compare_outputs();
      end
    end
    $display("Summary: %0d checks, window errors %0d, interrupt errors %0d, colour errors %0d",
             checks, err_count[0], err_count[1], err_count[2]);
    if (err_count[0] + err_count[1] + err_count[2] == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- compile.f
vdp_pkg.sv
vdp_frame_zone.sv
vdp_interrupt.sv
vdp_video_out.sv
vdp_display.sv
tb_vdp_display.sv

//--- Bender.yml
package:
  name: vdp_display

sources:
  - vdp_pkg.sv
  - vdp_frame_zone.sv
  - vdp_interrupt.sv
  - vdp_video_out.sv
  - vdp_display.sv
  - target: simulation
    files:
      - tb_vdp_display.sv
